// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_disparity_filtering_system
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Regression failed
PASS_MSG   ?= Regression passed
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation clean"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/conf_disp_divide.sv ====
// quotient saturates at 8 bits and a zero confidence sum yields 0; latency is DIV_LAT
module conf_disp_divide import disp_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [SUM_DC_BITS-1:0]  sum_dc,
    input  logic [SUM_C_BITS-1:0]   sum_c,
    input  logic                    f_valid,
    output logic [OUT_BITS-1:0]     disparity,
    output logic                    disparity_valid
);

    localparam int L = DIV_LAT - 1;

    logic [NUM_BITS-1:0]   rem_q  [0:DIV_LAT-2];
    logic [SUM_C_BITS-1:0] den_q  [0:DIV_LAT-2];
    logic [QUO_BITS-1:0]   quo_q  [0:L];
    logic [CONF_BITS-1:0]  cavg_q [0:L];       // delay-matched average confidence
    logic                  sat_q  [0:L];
    logic                  zero_q [0:L];
    logic [DIV_LAT-1:0]    vld_q;
    logic [NUM_BITS-1:0]   trial  [1:L];
    logic                  take   [1:L];
    logic                  sat_d;

    // quotient overflows 8 bits when sum_dc*8 >= sum_c*256
    assign sat_d = ((NUM_BITS + 1)'(sum_dc) << FRAC_BITS) >=
                   ((NUM_BITS + 1)'(sum_c) << QUO_BITS);

    always_comb begin
        for (int s = 1; s <= L; s++) begin
            trial[s] = NUM_BITS'(den_q[s-1]) << (QUO_BITS - s);
            take[s]  = rem_q[s-1] >= trial[s];
        end
    end

    always_ff @(posedge clk) begin
        rem_q[0]  <= NUM_BITS'(sum_dc) << FRAC_BITS;
        den_q[0]  <= sum_c;
        quo_q[0]  <= '0;
        cavg_q[0] <= CONF_BITS'(sum_c / TAPS);
        sat_q[0]  <= sat_d;
        zero_q[0] <= (sum_c == '0);
        for (int s = 1; s <= L; s++) begin
            quo_q[s]  <= quo_q[s-1] | (QUO_BITS'(take[s]) << (QUO_BITS - s));
            cavg_q[s] <= cavg_q[s-1];
            sat_q[s]  <= sat_q[s-1];
            zero_q[s] <= zero_q[s-1];
        end
        for (int s = 1; s < L; s++) begin
            rem_q[s] <= take[s] ? rem_q[s-1] - trial[s] : rem_q[s-1];   // restoring step
            den_q[s] <= den_q[s-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            vld_q <= '0;
        else
            vld_q <= {vld_q[DIV_LAT-2:0], f_valid};
    end

    assign disparity[OUT_BITS-1:QUO_BITS] = cavg_q[L];
    assign disparity[QUO_BITS-1:0]        = zero_q[L] ? '0 : (sat_q[L] ? '1 : quo_q[L]);
    assign disparity_valid                = vld_q[L];

endmodule

// ==== hw/disp_pkg.sv ====
// sizes assume power-of-two DEC and a line made of whole blocks; changing DIV_LAT needs QUO_BITS
package disp_pkg;

    // ************************************************************************
    // block geometry
    // ************************************************************************
    localparam int BLK_W        = 16;
    localparam int BLK_H        = 16;
    localparam int BLK_SIZE     = BLK_W * BLK_H;     // xor field width
    localparam int DEC          = 2;                 // decimation factor
    localparam int PIX_PER_BLK  = BLK_W / DEC;
    localparam int FRAME_W      = 32;
    localparam int LINE_LEN     = FRAME_W / DEC;     // decimated pixels per line
    localparam int SEARCH_W     = 48;
    localparam int COORD_BITS   = 16;

    localparam int COL_BITS     = $clog2(BLK_W);
    localparam int ROW_CNT_BITS = $clog2(BLK_H + 1);
    localparam int PIX_CNT_BITS = $clog2(PIX_PER_BLK);
    localparam int POS_BITS     = $clog2(LINE_LEN);
    localparam int CLR_BITS     = $clog2(DEC + 1);

    // ************************************************************************
    // datapath widths
    // ************************************************************************
    localparam int DISP_BITS    = $clog2(SEARCH_W - BLK_W);
    localparam int CONF_BITS    = 8;
    localparam int DC_BITS      = CONF_BITS + DISP_BITS;
    localparam int WPROD_BITS   = CONF_BITS + CLR_BITS;
    localparam int TAPS         = 3;
    localparam int SUM_C_BITS   = 10;
    localparam int SUM_DC_BITS  = 15;
    localparam int FRAC_BITS    = 3;
    localparam int NUM_BITS     = SUM_DC_BITS + FRAC_BITS;  // dividend width
    localparam int QUO_BITS     = 8;
    localparam int OUT_BITS     = CONF_BITS + QUO_BITS;

    // ************************************************************************
    // timing
    // ************************************************************************
    localparam int DIV_LAT      = QUO_BITS + 1;      // flag stage plus one per bit
    localparam int BLK_GAP      = PIX_PER_BLK + 1;

endpackage

// ==== hw/disparity_filtering_system.sv ====
// valid-only stream without back-pressure; sources must keep blocks BLK_GAP cycles apart
module disparity_filtering_system import disp_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [BLK_SIZE-1:0]    xors_in,
    input  logic [CONF_BITS-1:0]   confidence,
    input  logic [COORD_BITS-1:0]  min_coords,
    input  logic                   xors_valid,
    output logic [OUT_BITS-1:0]    disparity,    // {avg conf, disp 5.3}
    output logic                   disparity_valid,
    output logic                   overrun
);

    logic [DEC-1:0]         pix_data;
    logic [DISP_BITS-1:0]   pix_disp;
    logic [CONF_BITS-1:0]   pix_conf;
    logic                   pix_valid;

    logic [DC_BITS-1:0]     dc;
    logic [CONF_BITS-1:0]   conf;
    logic                   pp_valid;

    logic [SUM_DC_BITS-1:0] sum_dc;
    logic [SUM_C_BITS-1:0]  sum_c;
    logic                   f_valid;

    xors_to_stream i_xors_to_stream (
        .clk        (clk),
        .arst_n     (arst_n),
        .xors_in    (xors_in),
        .confidence (confidence),
        .min_coords (min_coords),
        .xors_valid (xors_valid),
        .pix_data   (pix_data),
        .pix_disp   (pix_disp),
        .pix_conf   (pix_conf),
        .pix_valid  (pix_valid),
        .overrun    (overrun)
    );

    pixel_processor i_pixel_processor (
        .clk       (clk),
        .arst_n    (arst_n),
        .pix_data  (pix_data),
        .pix_disp  (pix_disp),
        .pix_conf  (pix_conf),
        .pix_valid (pix_valid),
        .dc        (dc),
        .conf      (conf),
        .pp_valid  (pp_valid)
    );

    filter_and_pad i_filter_and_pad (
        .clk      (clk),
        .arst_n   (arst_n),
        .dc       (dc),
        .conf     (conf),
        .pp_valid (pp_valid),
        .sum_dc   (sum_dc),
        .sum_c    (sum_c),
        .f_valid  (f_valid)
    );

    conf_disp_divide i_conf_disp_divide (
        .clk             (clk),
        .arst_n          (arst_n),
        .sum_dc          (sum_dc),
        .sum_c           (sum_c),
        .f_valid         (f_valid),
        .disparity       (disparity),
        .disparity_valid (disparity_valid)
    );

endmodule

// ==== hw/filter_and_pad.sv ====
// needs an idle cycle after each line's last pixel for the flush; BLK_GAP spacing provides it
module filter_and_pad import disp_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [DC_BITS-1:0]      dc,
    input  logic [CONF_BITS-1:0]    conf,
    input  logic                    pp_valid,
    output logic [SUM_DC_BITS-1:0]  sum_dc,
    output logic [SUM_C_BITS-1:0]   sum_c,
    output logic                    f_valid
);

    // h1/c1 hold entry pos-1, h2/c2 hold entry pos-2
    logic [DC_BITS-1:0]   h1;
    logic [DC_BITS-1:0]   h2;
    logic [CONF_BITS-1:0] c1;
    logic [CONF_BITS-1:0] c2;
    logic [DC_BITS-1:0]   left_dc;
    logic [CONF_BITS-1:0] left_c;
    logic [POS_BITS-1:0]  pos;
    logic                 flush;
    logic                 mid_out;
    logic                 last_pix;

    assign mid_out  = pp_valid && (pos != '0);    // pixel pos-1 has its right neighbour
    assign last_pix = pp_valid && (pos == POS_BITS'(LINE_LEN - 1));

    // left neighbour of pixel pos-1 is padding at the line start
    always_comb begin
        if (pos == POS_BITS'(1)) begin
            left_dc = '0;
            left_c  = '0;
        end else begin
            left_dc = h2;
            left_c  = c2;
        end
    end

    always_ff @(posedge clk) begin
        if (pp_valid) begin
            h1 <= dc;
            h2 <= h1;
            c1 <= conf;
            c2 <= c1;
        end
        if (mid_out) begin
            sum_dc <= SUM_DC_BITS'(left_dc) + SUM_DC_BITS'(h1) + SUM_DC_BITS'(dc);
            sum_c  <= SUM_C_BITS'(left_c) + SUM_C_BITS'(c1) + SUM_C_BITS'(conf);
        end else if (flush) begin
            sum_dc <= SUM_DC_BITS'(h2) + SUM_DC_BITS'(h1);   // zero pad on the right
            sum_c  <= SUM_C_BITS'(c2) + SUM_C_BITS'(c1);
        end
    end

    // ************************************************************************
    // line position and output strobe
    // ************************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pos     <= '0;
            flush   <= 1'b0;
            f_valid <= 1'b0;
        end else begin
            f_valid <= mid_out || flush;
            flush   <= last_pix;
            if (pp_valid)
                pos <= last_pix ? '0 : pos + 1'b1;
        end
    end

endmodule

// ==== hw/pixel_processor.sv ====
// fixed two-cycle latency; weight is confidence scaled by the fraction of clear bits
module pixel_processor import disp_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [DEC-1:0]        pix_data,
    input  logic [DISP_BITS-1:0]  pix_disp,
    input  logic [CONF_BITS-1:0]  pix_conf,
    input  logic                  pix_valid,
    output logic [DC_BITS-1:0]    dc,
    output logic [CONF_BITS-1:0]  conf,
    output logic                  pp_valid
);

    logic [CLR_BITS-1:0]   clear_cnt;
    logic [CONF_BITS-1:0]  weight;
    logic [CONF_BITS-1:0]  w_q;
    logic [DISP_BITS-1:0]  d_q;
    logic                  v_q;

    always_comb begin
        clear_cnt = CLR_BITS'(DEC);
        for (int k = 0; k < DEC; k++)
            clear_cnt = clear_cnt - CLR_BITS'(pix_data[k]);
        // full, half (floor) or zero for DEC of 2
        weight = CONF_BITS'((WPROD_BITS'(pix_conf) * WPROD_BITS'(clear_cnt)) / DEC);
    end

    always_ff @(posedge clk) begin
        w_q  <= weight;
        d_q  <= pix_disp;
        dc   <= DC_BITS'(w_q) * DC_BITS'(d_q);   // multiply in the second stage
        conf <= w_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_q      <= 1'b0;
            pp_valid <= 1'b0;
        end else begin
            v_q      <= pix_valid;
            pp_valid <= v_q;
        end
    end

endmodule

// ==== hw/xors_to_stream.sv ====
// no ready: a block arriving while busy is dropped and sets sticky overrun until reset
module xors_to_stream import disp_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [BLK_SIZE-1:0]      xors_in,     // bit r*BLK_W+c is row r, column c
    input  logic [CONF_BITS-1:0]     confidence,
    input  logic [COORD_BITS-1:0]    min_coords,
    input  logic                     xors_valid,
    output logic [DEC-1:0]           pix_data,
    output logic [DISP_BITS-1:0]     pix_disp,
    output logic [CONF_BITS-1:0]     pix_conf,
    output logic                     pix_valid,
    output logic                     overrun
);

    logic [BLK_SIZE-1:0]     blk_q;
    logic [CONF_BITS-1:0]    conf_q;
    logic [DISP_BITS-1:0]    disp_q;
    logic                    busy;
    logic [PIX_CNT_BITS-1:0] cnt;
    logic [COL_BITS-1:0]     col_base;
    logic [ROW_CNT_BITS-1:0] ones [DEC];
    logic                    accept;

    assign accept = xors_valid && !busy;

    always_ff @(posedge clk) begin
        if (accept) begin
            blk_q  <= xors_in;
            conf_q <= confidence;
            disp_q <= min_coords[DISP_BITS-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            cnt     <= '0;
            overrun <= 1'b0;
        end else begin
            if (xors_valid && busy)
                overrun <= 1'b1;        // sticky
            if (accept) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == PIX_CNT_BITS'(PIX_PER_BLK - 1))
                    busy <= 1'b0;
            end
        end
    end

    // ************************************************************************
    // column majority vote for the current pixel
    // ************************************************************************
    assign col_base = COL_BITS'(cnt * DEC);

    always_comb begin
        for (int k = 0; k < DEC; k++) begin
            ones[k] = '0;
            for (int r = 0; r < BLK_H; r++)
                ones[k] = ones[k] + ROW_CNT_BITS'(blk_q[r * BLK_W + col_base + k]);
            pix_data[k] = (ones[k] > ROW_CNT_BITS'(BLK_H / 2));  // more than half mismatch
        end
    end

    assign pix_disp  = disp_q;
    assign pix_conf  = conf_q;
    assign pix_valid = busy;

endmodule

// ==== verif/disparity_checker.sv ====
// bound inside the top level; busy is the stream stage's pixel valid, high while a block is in flight
module disparity_checker (
    input  logic clk,
    input  logic arst_n,
    input  logic xors_valid,
    input  logic busy,
    input  logic disparity_valid,
    input  logic overrun
);

    // ************************************************************************
    // reset and sticky overrun
    // ************************************************************************
    reset_quiet: assert property (
        @(posedge clk) !arst_n |-> (!disparity_valid && !overrun)
    ) else $error("output valid or overrun high during reset");

    overrun_sticky: assert property (
        @(posedge clk) disable iff (!arst_n) !$fell(overrun)
    ) else $error("overrun fell without a reset");

    // overrun only rises for a block that hit a busy stream stage
    overrun_cause: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(overrun) |-> ($past(xors_valid) && $past(busy))
    ) else $error("overrun rose without a block arriving while busy");

endmodule

// ==== verif/tb_disparity_filtering_system.sv ====
// each line is sent as two whole blocks; expected words queue in order and are checked on arrival
module tb_disparity_filtering_system import disp_pkg::*; ();

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic [BLK_SIZE-1:0]    xors_in;
    logic [CONF_BITS-1:0]   confidence;
    logic [COORD_BITS-1:0]  min_coords;
    logic                   xors_valid;
    logic [OUT_BITS-1:0]    disparity;
    logic                   disparity_valid;
    logic                   overrun;

    logic [OUT_BITS-1:0]    exp_q [$];
    logic [OUT_BITS-1:0]    head;
    logic [BLK_SIZE-1:0]    line_x [2];      // the two blocks of the current line
    logic [CONF_BITS-1:0]   line_c [2];
    logic [COORD_BITS-1:0]  line_m [2];
    int                     errors    = 0;
    int                     out_count = 0;
    int                     exp_total = 0;

    always #4 clk = ~clk;

    disparity_filtering_system i_disparity_filtering_system (
        .clk             (clk),
        .arst_n          (arst_n),
        .xors_in         (xors_in),
        .confidence      (confidence),
        .min_coords      (min_coords),
        .xors_valid      (xors_valid),
        .disparity       (disparity),
        .disparity_valid (disparity_valid),
        .overrun         (overrun)
    );

    bind disparity_filtering_system disparity_checker i_disparity_checker (
        .clk             (clk),
        .arst_n          (arst_n),
        .xors_valid      (xors_valid),
        .busy            (pix_valid),
        .disparity_valid (disparity_valid),
        .overrun         (overrun)
    );

    task automatic check_value(input string name, input logic [31:0] expv, input logic [31:0] got);
        assert (got == expv) else begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, expv, got);
        end
    endtask

    // outputs are sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (arst_n && disparity_valid) begin
            out_count++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("disparity output arrived while no output was expected");
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                check_value("disparity", 32'(head), 32'(disparity));
            end
        end
    end

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apply_reset();
        arst_n     = 1'b0;
        xors_valid = 1'b0;
        step(3);
        arst_n     = 1'b1;
    endtask

    task automatic send_block(input logic [BLK_SIZE-1:0] x, input logic [CONF_BITS-1:0] c,
                              input logic [COORD_BITS-1:0] m, input int gap);
        xors_in    = x;
        confidence = c;
        min_coords = m;
        xors_valid = 1'b1;
        step(1);
        xors_valid = 1'b0;
        step(gap - 1);
    endtask

    // ************************************************************************
    // reference model
    // ************************************************************************
    function automatic int pixel_weight(input logic [BLK_SIZE-1:0] x, input int pix, input int c);
        int clear;
        int ones;
        clear = DEC;
        for (int k = 0; k < DEC; k++) begin
            ones = 0;
            for (int r = 0; r < BLK_H; r++)
                ones += int'(x[r * BLK_W + pix * DEC + k]);
            if (ones > BLK_H / 2)
                clear--;                     // majority of rows mismatch
        end
        if (clear == 2)
            return c;
        else if (clear == 1)
            return c / 2;
        return 0;
    endfunction

    task automatic model_line();
        int w   [LINE_LEN];
        int dcv [LINE_LEN];
        int b;
        int sc;
        int sd;
        int q;
        for (int p = 0; p < LINE_LEN; p++) begin
            b      = p / PIX_PER_BLK;
            w[p]   = pixel_weight(line_x[b], p % PIX_PER_BLK, int'(line_c[b]));
            dcv[p] = w[p] * int'(line_m[b][DISP_BITS-1:0]);
        end
        for (int j = 0; j < LINE_LEN; j++) begin
            sc = 0;
            sd = 0;
            for (int t = j - 1; t <= j + 1; t++) begin
                if (t >= 0 && t < LINE_LEN) begin   // zero padding past the ends
                    sc += w[t];
                    sd += dcv[t];
                end
            end
            q = (sc == 0) ? 0 : (sd << FRAC_BITS) / sc;
            if (q > 255)
                q = 255;
            exp_q.push_back({8'(sc / TAPS), 8'(q)});
        end
        exp_total += LINE_LEN;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 40 * LINE_LEN) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timeout: %0d expected disparity outputs never came", exp_q.size());
            exp_q.delete();
        end
        step(2 * BLK_GAP);                   // give stray outputs a chance to show
        check_value("out_count", 32'(exp_total), 32'(out_count));
    endtask

    function automatic logic [BLK_SIZE-1:0] fill_column(input logic [BLK_SIZE-1:0] x,
                                                        input int col, input int rows);
        logic [BLK_SIZE-1:0] y;
        y = x;
        for (int r = 0; r < rows; r++)
            y[r * BLK_W + col] = 1'b1;
        return y;
    endfunction

    // ************************************************************************
    // directed tests
    // ************************************************************************
    task automatic uniform_line();
        exp_q.push_back(16'h5550);          // left end, conf 256/3
        repeat (LINE_LEN - 2) exp_q.push_back(16'h8050);
        exp_q.push_back(16'h5550);
        exp_total += LINE_LEN;
        send_block('0, 8'h80, 16'd10, BLK_GAP);
        send_block('0, 8'h80, 16'd10, BLK_GAP);
        wait_drain();
    endtask

    task automatic column_weighting();
        int n;
        for (int b = 0; b < 2; b++) begin
            line_x[b] = '0;
            for (int i = 0; i < PIX_PER_BLK; i++) begin
                n = (i + b) % 3;             // majority columns in this group
                if (n >= 1)
                    line_x[b] = fill_column(line_x[b], i * DEC, BLK_H / 2 + 1);
                if (n == 2)
                    line_x[b] = fill_column(line_x[b], i * DEC + 1, BLK_H);
                if (n == 0)
                    line_x[b] = fill_column(line_x[b], i * DEC + 1, BLK_H / 2);  // half is no majority
            end
        end
        line_c[0] = 8'hc8;
        line_m[0] = 16'h0017;
        line_c[1] = 8'h3b;
        line_m[1] = 16'hffe7;                // only the low bits carry disparity
        model_line();
        send_block(line_x[0], line_c[0], line_m[0], BLK_GAP);
        send_block(line_x[1], line_c[1], line_m[1], BLK_GAP + 2);
        wait_drain();
    endtask

    task automatic zero_confidence_line();
        repeat (LINE_LEN) exp_q.push_back('0);
        exp_total += LINE_LEN;
        send_block('1, 8'hff, 16'h0011, BLK_GAP);   // every column mismatches
        send_block('0, 8'h00, 16'h001f, BLK_GAP);
        wait_drain();
    endtask

    task automatic random_lines();
        int mode;
        for (int l = 0; l < 20; l++) begin
            for (int b = 0; b < 2; b++) begin
                mode = int'($urandom_range(2));
                for (int n = 0; n < BLK_SIZE / 32; n++) begin
                    case (mode)
                        0:       line_x[b][n*32 +: 32] = $urandom() & $urandom();
                        1:       line_x[b][n*32 +: 32] = $urandom();
                        default: line_x[b][n*32 +: 32] = $urandom() | $urandom();
                    endcase
                end
                line_c[b] = CONF_BITS'($urandom());
                line_m[b] = COORD_BITS'($urandom());
            end
            model_line();
            send_block(line_x[0], line_c[0], line_m[0], BLK_GAP + int'($urandom_range(3)));
            send_block(line_x[1], line_c[1], line_m[1], BLK_GAP + int'($urandom_range(3)));
        end
        wait_drain();
    endtask

    task automatic overrun_drop();
        line_x[0] = fill_column('0, 3, BLK_H);
        line_c[0] = 8'h64;
        line_m[0] = 16'h0009;
        line_x[1] = '0;
        line_c[1] = 8'h90;
        line_m[1] = 16'h0004;
        model_line();
        send_block(line_x[0], line_c[0], line_m[0], 3);
        send_block('1, 8'hff, 16'h001f, BLK_GAP - 3);  // lands while busy
        check_value("overrun", 32'h1, 32'(overrun));
        send_block(line_x[1], line_c[1], line_m[1], BLK_GAP);
        wait_drain();
        check_value("overrun", 32'h1, 32'(overrun));
        send_block(line_x[1], line_c[1], line_m[1], 4);  // still in flight at reset
        apply_reset();
        check_value("overrun", 32'h0, 32'(overrun));
        step(2 * BLK_GAP + DIV_LAT);                     // flushed pixels must not come out
        check_value("out_count", 32'(exp_total), 32'(out_count));
    endtask

    initial begin
        void'($urandom(32'h629a_60db));
        arst_n     = 1'b1;
        xors_in    = '0;
        confidence = '0;
        min_coords = '0;
        xors_valid = 1'b0;
        #1;
        apply_reset();
        uniform_line();
        column_weighting();
        zero_confidence_line();
        random_lines();
        overrun_drop();
        $display("errors: %0d, outputs seen: %0d of %0d", errors, out_count, exp_total);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/disp_pkg.sv
hw/xors_to_stream.sv
hw/pixel_processor.sv
hw/filter_and_pad.sv
hw/conf_disp_divide.sv
hw/disparity_filtering_system.sv
verif/disparity_checker.sv
verif/tb_disparity_filtering_system.sv
